// ==== sim.f ====
verilog/hv_reg_pkg.sv
verilog/hv_ctrl_pkg.sv
verilog/spi_slv.sv
verilog/lv_reg_slv.sv
verilog/lv_wdg_ctrl.sv
verilog/lv_ctrl_unit.sv
verilog/lv_dgt_pwm_ctrl.sv
verilog/hv_core.sv
bench/tb_hv_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the hv_core testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_hv_core -o tb_hv_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_hv_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAIL" "$LOG"; then
    exit 1
fi
exit 0

// ==== bench/tb_hv_core.sv ====
`timescale 1ns/1ps
// testbench for hv_core, frames and expected responses come from a table
// spi is bit-banged at 8 clocks per half sclk, frames spaced by 12 clocks
// state is seen on the pins, plus STATE register reads in the table
module tb_hv_core import hv_reg_pkg::*; import hv_ctrl_pkg::*; ();

localparam int SPI_HALF_PERIOD = 8;

typedef struct packed {
    spi_frame_t frm;
    logic [4:0] nbits;
    spi_frame_t exp_rsp;   // shows up during the next frame
    ctrl_st_e   exp_st;
    drv_cfg_t   exp_cfg;
    logic       wait_int;  // fault comes later than the frame
} step_t;

logic     i_clk;
logic     i_rst;
logic     i_spi_sclk;
logic     i_spi_csb;
logic     i_spi_mosi;
logic     i_pwr_on;
logic     i_ang_dgt_pwm_wv;
logic     i_ang_dgt_pwm_fs;
logic     o_spi_miso;
logic     o_dgt_ang_pwm_en;
logic     o_dgt_ang_fsc_en;
logic     o_io_pwm_l2h;
logic     o_intb_n;
drv_cfg_t o_reg_drv_cfg;

step_t    tbl[$];
drv_cfg_t mdl_cfg;
int       seed = 36;
int       frame_errs = 0;
int       cfg_errs = 0;
int       bit_errs = 0;
int       tmo_errs = 0;

hv_core uut (.*);

initial begin
    i_clk = 1'b0;
    forever #20 i_clk = ~i_clk;
end

//======================================================================
// reference model and compare tasks
//======================================================================
function automatic logic [7:0] crc_model(input logic [15:0] bits);
    logic [7:0] c;
    logic       fb;
    c = 8'h00;
    for (int i = 15; i >= 0; i--) begin
        fb = c[7] ^ bits[i];
        c  = {c[6:0], 1'b0} ^ (fb ? 8'h07 : 8'h00);
    end
    return c;
endfunction

function automatic spi_frame_t make_frame(input logic rw, input logic [6:0] addr,
                                          input logic [7:0] data);
    spi_frame_t f;
    f.rw   = rw;
    f.addr = addr;
    f.data = data;
    f.crc  = crc_model({rw, addr, data});
    return f;
endfunction

task automatic check_frame(input string name, input spi_frame_t got, input spi_frame_t exp,
                           input logic full);
    if (full ? (got !== exp) : (got.rw !== exp.rw)) begin
        frame_errs++;
        $display("FAIL %s got 0x%06h exp 0x%06h", name, got, exp);
    end
endtask

task automatic check_cfg(input drv_cfg_t got, input drv_cfg_t exp);
    if (got !== exp) begin
        cfg_errs++;
        $display("FAIL o_reg_drv_cfg got 0x%08h exp 0x%08h", got, exp);
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        bit_errs++;
        $display("FAIL %s got 0x%h exp 0x%h", name, got, exp);
    end
endtask

task automatic check_state(input ctrl_st_e st);
    check_bit("o_intb_n", o_intb_n, st != FAULT);
    check_bit("o_dgt_ang_fsc_en", o_dgt_ang_fsc_en, st == FAULT);
    check_bit("o_dgt_ang_pwm_en", o_dgt_ang_pwm_en, st == NORMAL);
endtask

//======================================================================
// drivers and waits
//======================================================================
task automatic wait_clks(input int n);
    repeat (n) @(negedge i_clk);
endtask

task automatic wait_fault(input int limit, input string what);
    int n;
    n = 0;
    while (o_intb_n && n < limit) begin
        @(negedge i_clk);
        n++;
    end
    if (o_intb_n) begin
        tmo_errs++;
        $display("no interrupt within %0d clocks after %s", limit, what);
    end
endtask

task automatic send_frame(input spi_frame_t frm, input logic [4:0] nbits,
                          output spi_frame_t rsp);
    rsp       = '0;
    i_spi_csb = 1'b0;
    for (int i = 0; i < int'(nbits); i++) begin
        i_spi_mosi = frm[SPI_FRAME_W-1-i];
        wait_clks(SPI_HALF_PERIOD);
        rsp[SPI_FRAME_W-1-i] = o_spi_miso;  // sampled at sclk rise
        i_spi_sclk = 1'b1;
        wait_clks(SPI_HALF_PERIOD);
        i_spi_sclk = 1'b0;
    end
    wait_clks(SPI_HALF_PERIOD);
    i_spi_csb = 1'b1;
    wait_clks(12);  // request, register and state update
endtask

// one table row, cfg model follows accepted drive config writes
task automatic add_step(input logic rw, input logic [6:0] addr, input logic [7:0] data,
                        input logic ack, input logic [7:0] rd_exp, input ctrl_st_e st,
                        input logic [4:0] nbits = 5'd24, input logic bad_crc = 1'b0,
                        input logic wait_int = 1'b0);
    step_t s;
    s.frm = make_frame(rw, addr, data);
    if (bad_crc) begin
        s.frm.crc = ~s.frm.crc;
    end
    s.nbits   = nbits;
    s.exp_rsp = make_frame(ack, addr, rw ? data : rd_exp);
    s.exp_st  = st;
    if (rw && ack && addr[6:2] == ADDR_DRV_CFG0[6:2]) begin
        mdl_cfg[addr[1:0]*8 +: 8] = data;
    end
    s.exp_cfg  = mdl_cfg;
    s.wait_int = wait_int;
    tbl.push_back(s);
endtask

//======================================================================
// main sequence
//======================================================================
initial begin
    spi_frame_t rsp;
    spi_frame_t prev_exp;
    logic       prev_full;
    logic [7:0] d [6];
    i_rst            = 1'b1;
    i_spi_sclk       = 1'b0;
    i_spi_csb        = 1'b1;
    i_spi_mosi       = 1'b0;
    i_pwr_on         = 1'b0;
    i_ang_dgt_pwm_wv = 1'b0;
    i_ang_dgt_pwm_fs = 1'b0;
    mdl_cfg          = DRV_CFG_RST;
    for (int k = 0; k < 6; k++) begin
        d[k] = 8'($random(seed));
    end

    add_step(0, ADDR_STATE, 8'h00, 1, 8'(CFG), CFG);
    for (int k = 0; k < 4; k++) begin
        add_step(1, 7'(ADDR_DRV_CFG0 + k), d[k], 1, 8'h00, CFG);
    end
    add_step(0, ADDR_DRV_CFG0, 8'h00, 1, d[0], CFG);
    add_step(0, 7'(ADDR_DRV_CFG0 + 3), 8'h00, 1, d[3], CFG);
    add_step(1, ADDR_DRV_CFG0, d[4], 0, 8'h00, FAULT, 5'd24, 1);  // bad crc
    add_step(0, ADDR_STATUS1, 8'h00, 1, 8'h01, FAULT);
    add_step(1, ADDR_STATUS1, 8'h01, 1, 8'h00, FAULT);
    add_step(1, ADDR_MODE, 8'h02, 1, 8'h00, CFG);
    add_step(1, ADDR_MODE, 8'h01, 0, 8'h00, FAULT, 5'd20);  // short frame
    add_step(0, ADDR_STATUS1, 8'h00, 1, 8'h01, FAULT);
    add_step(1, ADDR_STATUS1, 8'h01, 1, 8'h00, FAULT);
    add_step(1, ADDR_MODE, 8'h02, 1, 8'h00, CFG);
    add_step(1, ADDR_MODE, 8'h01, 1, 8'h00, NORMAL);
    add_step(1, 7'(ADDR_DRV_CFG0 + 1), d[5], 0, 8'h00, FAULT);  // not in CFG
    add_step(0, ADDR_STATUS1, 8'h00, 1, 8'h01, FAULT);
    add_step(1, ADDR_STATUS1, 8'h01, 1, 8'h00, FAULT);
    add_step(1, ADDR_MODE, 8'h02, 1, 8'h00, CFG);
    add_step(1, ADDR_COM_CONFIG2, 8'h0f, 1, 8'h00, CFG);
    add_step(0, ADDR_COM_CONFIG2, 8'h00, 1, 8'h0f, CFG);
    add_step(1, ADDR_MODE, 8'h01, 1, 8'h00, NORMAL);
    for (int k = 0; k < 3; k++) begin
        add_step(0, ADDR_STATE, 8'h00, 1, 8'(NORMAL), NORMAL);
        add_step(1, ADDR_WDG_REFRESH, 8'h00, 1, 8'h00, NORMAL);
    end
    add_step(1, ADDR_COM_CONFIG2, 8'h01, 1, 8'h00, FAULT, 5'd24, 0, 1);
    add_step(0, ADDR_STATUS1, 8'h00, 1, 8'h02, FAULT);
    add_step(1, ADDR_STATUS1, 8'h02, 1, 8'h00, FAULT);
    add_step(1, ADDR_COM_CONFIG2, 8'h00, 1, 8'h00, FAULT);  // watchdog off
    add_step(1, ADDR_MODE, 8'h02, 1, 8'h00, CFG);
    add_step(1, ADDR_MODE, 8'h01, 1, 8'h00, NORMAL);

    wait_clks(10);
    i_rst = 1'b0;
    check_bit("o_spi_miso", o_spi_miso, 1'b0);
    check_bit("o_io_pwm_l2h", o_io_pwm_l2h, 1'b0);
    check_state(INIT);
    check_cfg(o_reg_drv_cfg, DRV_CFG_RST);
    i_pwr_on = 1'b1;
    wait_clks(4);

    prev_exp  = '0;  // first response after reset
    prev_full = 1'b1;
    foreach (tbl[i]) begin
        send_frame(tbl[i].frm, tbl[i].nbits, rsp);
        check_frame("o_spi_miso frame", rsp, prev_exp, prev_full && tbl[i].nbits == 5'd24);
        if (tbl[i].wait_int) begin
            wait_fault(200, "watchdog timeout setup");
        end
        check_state(tbl[i].exp_st);
        check_cfg(o_reg_drv_cfg, tbl[i].exp_cfg);
        prev_exp  = tbl[i].exp_rsp;
        prev_full = (tbl[i].nbits == 5'd24);
    end

    // wave passes only while driving
    i_ang_dgt_pwm_wv = 1'b1;
    wait_clks(4);
    check_bit("o_io_pwm_l2h", o_io_pwm_l2h, 1'b1);
    i_ang_dgt_pwm_wv = 1'b0;
    wait_clks(4);
    check_bit("o_io_pwm_l2h", o_io_pwm_l2h, 1'b0);

    i_ang_dgt_pwm_fs = 1'b1;
    wait_fault(20, "fail-safe input rise");
    check_state(FAULT);
    i_ang_dgt_pwm_wv = 1'b1;
    wait_clks(4);
    check_bit("o_io_pwm_l2h", o_io_pwm_l2h, 1'b0);
    send_frame(make_frame(0, ADDR_STATUS1, 8'h00), 5'd24, rsp);
    check_frame("o_spi_miso frame", rsp, prev_exp, prev_full);
    send_frame(make_frame(0, ADDR_STATE, 8'h00), 5'd24, rsp);
    check_frame("o_spi_miso frame", rsp, make_frame(1, ADDR_STATUS1, 8'h04), 1'b1);

    $display("errors: frame %0d, cfg %0d, bit %0d, timeout %0d",
             frame_errs, cfg_errs, bit_errs, tmo_errs);
    if (frame_errs + cfg_errs + bit_errs + tmo_errs == 0) begin
        $display("TEST PASS");
    end else begin
        $display("TEST FAIL");
    end
    $finish;
end

endmodule

// ==== verilog/hv_core.sv ====
`timescale 1ns/1ps
// host side of the low voltage control core
// spi register access, mode FSM, watchdog and pwm gate
module hv_core import hv_reg_pkg::*; import hv_ctrl_pkg::*; (
    input  logic     i_clk,
    input  logic     i_rst,
    input  logic     i_spi_sclk,
    input  logic     i_spi_csb,
    input  logic     i_spi_mosi,
    input  logic     i_pwr_on,
    input  logic     i_ang_dgt_pwm_wv,
    input  logic     i_ang_dgt_pwm_fs,
    output logic     o_spi_miso,
    output logic     o_dgt_ang_pwm_en,
    output logic     o_dgt_ang_fsc_en,
    output logic     o_io_pwm_l2h,
    output logic     o_intb_n,
    output drv_cfg_t o_reg_drv_cfg
);

reg_req_t     spi_req;
reg_rsp_t     reg_rsp;
err_evt_t     err_evt;
reg_status1_t status1;
ctrl_st_e     cur_st;
logic [3:0]   wdg_tmo_cfg;
logic         nml_en;
logic         rst_en;
logic         wdg_refresh;
logic         wdg_en;
logic         fsm_pwm_en;
logic         fsm_fsc_en;

spi_slv u_spi_slv (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_spi_sclk (i_spi_sclk),
    .i_spi_csb  (i_spi_csb),
    .i_spi_mosi (i_spi_mosi),
    .i_rsp      (reg_rsp),
    .o_spi_miso (o_spi_miso),
    .o_req      (spi_req),
    .o_spi_err  (err_evt.spi_err)
);

lv_reg_slv u_lv_reg_slv (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_req         (spi_req),
    .i_err         (err_evt),
    .i_cur_st      (cur_st),
    .o_rsp         (reg_rsp),
    .o_status1     (status1),
    .o_nml_en      (nml_en),
    .o_rst_en      (rst_en),
    .o_wdg_tmo_cfg (wdg_tmo_cfg),
    .o_wdg_refresh (wdg_refresh),
    .o_reg_drv_cfg (o_reg_drv_cfg)
);

lv_wdg_ctrl u_lv_wdg_ctrl (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_wdg_en  (wdg_en),
    .i_refresh (wdg_refresh),
    .i_tmo_cfg (wdg_tmo_cfg),
    .o_wdg_tmo (err_evt.wdg_tmo)
);

lv_ctrl_unit u_lv_ctrl_unit (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_pwr_on  (i_pwr_on),
    .i_nml_en  (nml_en),
    .i_rst_en  (rst_en),
    .i_status1 (status1),
    .o_cur_st  (cur_st),
    .o_pwm_en  (fsm_pwm_en),
    .o_fsc_en  (fsm_fsc_en),
    .o_wdg_en  (wdg_en),
    .o_intb_n  (o_intb_n)
);

lv_dgt_pwm_ctrl u_lv_dgt_pwm_ctrl (
    .i_clk            (i_clk),
    .i_rst            (i_rst),
    .i_ang_dgt_pwm_wv (i_ang_dgt_pwm_wv),
    .i_ang_dgt_pwm_fs (i_ang_dgt_pwm_fs),
    .i_fsm_pwm_en     (fsm_pwm_en),
    .i_fsm_fsc_en     (fsm_fsc_en),
    .o_dgt_ang_pwm_en (o_dgt_ang_pwm_en),
    .o_dgt_ang_fsc_en (o_dgt_ang_fsc_en),
    .o_io_pwm_l2h     (o_io_pwm_l2h),
    .o_pwm_fs_err     (err_evt.pwm_fs)
);

endmodule

// ==== verilog/lv_dgt_pwm_ctrl.sv ====
`timescale 1ns/1ps
// gate between the FSM and the analog driver
// wave and fail-safe inputs are async, two flop synchronized
// a fail-safe seen while driving cuts the enable before FAULT is reached
module lv_dgt_pwm_ctrl (
    input  logic i_clk,
    input  logic i_rst,
    input  logic i_ang_dgt_pwm_wv,
    input  logic i_ang_dgt_pwm_fs,
    input  logic i_fsm_pwm_en,
    input  logic i_fsm_fsc_en,
    output logic o_dgt_ang_pwm_en,
    output logic o_dgt_ang_fsc_en,
    output logic o_io_pwm_l2h,
    output logic o_pwm_fs_err
);

logic [1:0] wv_sync;
logic [2:0] fs_sync;  // extra stage for edge detect

always_ff @(posedge i_clk) begin
    if (i_rst) begin
        wv_sync      <= '0;
        fs_sync      <= '0;
        o_pwm_fs_err <= 1'b0;
    end else begin
        wv_sync      <= {wv_sync[0], i_ang_dgt_pwm_wv};
        fs_sync      <= {fs_sync[1:0], i_ang_dgt_pwm_fs};
        o_pwm_fs_err <= fs_sync[1] & ~fs_sync[2] & i_fsm_pwm_en;
    end
end

assign o_dgt_ang_pwm_en = i_fsm_pwm_en & ~fs_sync[1];
assign o_dgt_ang_fsc_en = i_fsm_fsc_en;
assign o_io_pwm_l2h     = wv_sync[1] & o_dgt_ang_pwm_en;

endmodule

// ==== verilog/lv_ctrl_unit.sv ====
`timescale 1ns/1ps
// mode FSM: INIT -> CFG -> NORMAL, any status error -> FAULT
// FAULT returns to CFG on reset_en once status is cleared
module lv_ctrl_unit import hv_reg_pkg::*; import hv_ctrl_pkg::*; (
    input  logic         i_clk,
    input  logic         i_rst,
    input  logic         i_pwr_on,
    input  logic         i_nml_en,
    input  logic         i_rst_en,
    input  reg_status1_t i_status1,
    output ctrl_st_e     o_cur_st,
    output logic         o_pwm_en,
    output logic         o_fsc_en,
    output logic         o_wdg_en,
    output logic         o_intb_n
);

ctrl_st_e nxt_st;
logic     err_any;

assign err_any = |i_status1;

always_comb begin
    nxt_st = o_cur_st;
    case (o_cur_st)
        INIT: begin
            if (i_pwr_on) nxt_st = CFG;
        end
        CFG: begin
            if (err_any) begin
                nxt_st = FAULT;
            end else if (i_nml_en) begin
                nxt_st = NORMAL;
            end
        end
        NORMAL: begin
            if (err_any) nxt_st = FAULT;
        end
        FAULT: begin
            if (i_rst_en && !err_any) nxt_st = CFG;
        end
        default: nxt_st = INIT;
    endcase
end

always_ff @(posedge i_clk) begin
    if (i_rst) begin
        o_cur_st <= INIT;
    end else begin
        o_cur_st <= nxt_st;
    end
end

assign o_pwm_en = (o_cur_st == NORMAL);
assign o_wdg_en = (o_cur_st == NORMAL);
assign o_fsc_en = (o_cur_st == FAULT);
assign o_intb_n = (o_cur_st != FAULT);  // active low interrupt

endmodule

// ==== verilog/lv_wdg_ctrl.sv ====
`timescale 1ns/1ps
// refresh watchdog, counts only while enabled
// period is timeout x WDG_TICK clocks, timeout 0 turns it off
module lv_wdg_ctrl import hv_ctrl_pkg::*; (
    input  logic       i_clk,
    input  logic       i_rst,
    input  logic       i_wdg_en,
    input  logic       i_refresh,
    input  logic [3:0] i_tmo_cfg,
    output logic       o_wdg_tmo
);

logic [WDG_CNT_W-1:0] cnt;
logic [3:0]           tmo_d;
logic                 en_d;
logic                 active;
logic                 load;

assign active = i_wdg_en & (i_tmo_cfg != 4'd0);
// enable rise, refresh or a new timeout value restarts the count
assign load   = active & (i_refresh | ~en_d | (i_tmo_cfg != tmo_d));

always_ff @(posedge i_clk) begin
    if (i_rst) begin
        cnt       <= '0;
        tmo_d     <= '0;
        en_d      <= 1'b0;
        o_wdg_tmo <= 1'b0;
    end else begin
        en_d      <= i_wdg_en;
        tmo_d     <= i_tmo_cfg;
        o_wdg_tmo <= active & ~load & (cnt == WDG_CNT_W'(1));
        if (!active) begin
            cnt <= '0;
        end else if (load) begin
            cnt <= WDG_CNT_W'(i_tmo_cfg) * WDG_CNT_W'(WDG_TICK);
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;  // holds at zero after expiry
        end
    end
end

endmodule

// ==== verilog/lv_reg_slv.sv ====
`timescale 1ns/1ps
// register file, answers a request in the same cycle
// status is write-one-to-clear, a new error wins over the clear
// drive config writes only in CFG, rejected writes flag spi_err
module lv_reg_slv import hv_reg_pkg::*; import hv_ctrl_pkg::*; (
    input  logic         i_clk,
    input  logic         i_rst,
    input  reg_req_t     i_req,
    input  err_evt_t     i_err,
    input  ctrl_st_e     i_cur_st,
    output reg_rsp_t     o_rsp,
    output reg_status1_t o_status1,
    output logic         o_nml_en,
    output logic         o_rst_en,
    output logic [3:0]   o_wdg_tmo_cfg,
    output logic         o_wdg_refresh,
    output drv_cfg_t     o_reg_drv_cfg
);

logic         hit_mode;
logic         hit_status;
logic         hit_state;
logic         hit_cfg2;
logic         hit_refresh;
logic         hit_drv;
logic         wr_ok;
logic         wr_rej;
logic [1:0]   drv_idx;
reg_mode_t    mode_wr;
reg_status1_t set_mask;
reg_status1_t clr_mask;

assign hit_mode    = (i_req.addr == ADDR_MODE);
assign hit_status  = (i_req.addr == ADDR_STATUS1);
assign hit_state   = (i_req.addr == ADDR_STATE);
assign hit_cfg2    = (i_req.addr == ADDR_COM_CONFIG2);
assign hit_refresh = (i_req.addr == ADDR_WDG_REFRESH);
assign hit_drv     = (i_req.addr[REG_AW-1:2] == ADDR_DRV_CFG0[REG_AW-1:2]);
assign drv_idx     = i_req.addr[1:0];
assign mode_wr     = i_req.wdata;

// state reg is read only, unmapped writes rejected
assign wr_ok  = hit_mode | hit_status | hit_cfg2 | hit_refresh | (hit_drv & (i_cur_st == CFG));
assign wr_rej = i_req.wen & ~wr_ok;

assign o_rsp.ack = i_req.ren | (i_req.wen & wr_ok);

always_comb begin
    o_rsp.rdata = '0;  // mode, refresh, unmapped
    if (i_req.ren) begin
        if (hit_status) begin
            o_rsp.rdata = o_status1;
        end else if (hit_state) begin
            o_rsp.rdata = REG_DW'(i_cur_st);
        end else if (hit_cfg2) begin
            o_rsp.rdata = REG_DW'(o_wdg_tmo_cfg);
        end else if (hit_drv) begin
            o_rsp.rdata = o_reg_drv_cfg[drv_idx*REG_DW +: REG_DW];
        end
    end
end

always_comb begin
    set_mask             = '0;
    set_mask.spi_err     = i_err.spi_err | wr_rej;
    set_mask.wdg_tmo_err = i_err.wdg_tmo;
    set_mask.pwm_fs_err  = i_err.pwm_fs;
    clr_mask             = '0;
    if (i_req.wen && hit_status) begin
        clr_mask = i_req.wdata;
    end
end

always_ff @(posedge i_clk) begin
    if (i_rst) begin
        o_status1     <= '0;
        o_nml_en      <= 1'b0;
        o_rst_en      <= 1'b0;
        o_wdg_refresh <= 1'b0;
        o_wdg_tmo_cfg <= '0;  // watchdog off
        o_reg_drv_cfg <= DRV_CFG_RST;
    end else begin
        o_status1     <= (o_status1 & ~clr_mask) | set_mask;
        o_nml_en      <= i_req.wen & hit_mode & mode_wr.normal_en;
        o_rst_en      <= i_req.wen & hit_mode & mode_wr.reset_en;
        o_wdg_refresh <= i_req.wen & hit_refresh;
        if (i_req.wen && hit_cfg2) begin
            o_wdg_tmo_cfg <= i_req.wdata[3:0];
        end
        if (i_req.wen && wr_ok && hit_drv) begin
            o_reg_drv_cfg[drv_idx*REG_DW +: REG_DW] <= i_req.wdata;
        end
    end
end

endmodule

// ==== verilog/spi_slv.sv ====
`timescale 1ns/1ps
// spi mode 0 slave, 24-bit frames checked by crc-8
// sclk must be at most i_clk/8, host spaces frames by a few i_clk
// miso carries the response to the previous frame, all zero after reset
module spi_slv import hv_reg_pkg::*; import hv_ctrl_pkg::*; (
    input  logic     i_clk,
    input  logic     i_rst,
    input  logic     i_spi_sclk,
    input  logic     i_spi_csb,
    input  logic     i_spi_mosi,
    input  reg_rsp_t i_rsp,
    output logic     o_spi_miso,
    output reg_req_t o_req,
    output logic     o_spi_err
);

logic [2:0]             pin_s1;     // {sclk, csb, mosi}
logic [2:0]             pin_s2;
logic [1:0]             pin_s3;     // {sclk, csb} edge history
logic                   sclk_rise;
logic                   sclk_fall;
logic                   csb_fall;
logic                   csb_rise;
logic [4:0]             bit_cnt;
logic [SPI_FRAME_W-1:0] rx_sr;
logic [SPI_FRAME_W-1:0] tx_sr;
spi_frame_t             rx_frm;
spi_frame_t             rsp_nxt;
spi_frame_t             rsp_word;
logic                   frm_ok;

//======================================================================
// pin synchronizers and edge detect
//======================================================================
always_ff @(posedge i_clk) begin
    if (i_rst) begin
        pin_s1 <= 3'b010;
        pin_s2 <= 3'b010;
        pin_s3 <= 2'b01;
    end else begin
        pin_s1 <= {i_spi_sclk, i_spi_csb, i_spi_mosi};
        pin_s2 <= pin_s1;
        pin_s3 <= pin_s2[2:1];
    end
end

assign sclk_rise = pin_s2[2] & ~pin_s3[1] & ~pin_s2[1];
assign sclk_fall = ~pin_s2[2] & pin_s3[1] & ~pin_s2[1];
assign csb_fall  = ~pin_s2[1] & pin_s3[0];
assign csb_rise  = pin_s2[1] & ~pin_s3[0];

always_ff @(posedge i_clk) begin
    if (i_rst) begin
        bit_cnt <= '0;
    end else if (csb_fall) begin
        bit_cnt <= '0;
    end else if (sclk_rise && bit_cnt != 5'h1f) begin
        bit_cnt <= bit_cnt + 5'd1;  // saturates on long frames
    end
end

always_ff @(posedge i_clk) begin
    if (sclk_rise) begin
        rx_sr <= {rx_sr[SPI_FRAME_W-2:0], pin_s2[0]};
    end
end

//======================================================================
// frame check and request
//======================================================================
assign rx_frm = rx_sr;
assign frm_ok = (bit_cnt == 5'(SPI_FRAME_W)) &&
                (rx_frm.crc == crc8_calc({rx_frm.rw, rx_frm.addr, rx_frm.data}));

always_ff @(posedge i_clk) begin
    if (i_rst) begin
        o_req     <= '0;
        o_spi_err <= 1'b0;
    end else begin
        o_req.wen <= csb_rise & frm_ok & rx_frm.rw;
        o_req.ren <= csb_rise & frm_ok & ~rx_frm.rw;
        o_spi_err <= csb_rise & ~frm_ok;
        if (csb_rise) begin
            o_req.addr  <= rx_frm.addr;
            o_req.wdata <= rx_frm.data;
        end
    end
end

// response for the next frame
always_comb begin
    if (o_req.wen | o_req.ren) begin
        rsp_nxt.rw   = i_rsp.ack;
        rsp_nxt.addr = o_req.addr;
        rsp_nxt.data = o_req.ren ? i_rsp.rdata : o_req.wdata;
    end else begin
        rsp_nxt.rw   = 1'b0;  // bad frame
        rsp_nxt.addr = rx_frm.addr;
        rsp_nxt.data = rx_frm.data;
    end
    rsp_nxt.crc = crc8_calc({rsp_nxt.rw, rsp_nxt.addr, rsp_nxt.data});
end

always_ff @(posedge i_clk) begin
    if (i_rst) begin
        rsp_word <= '0;
        tx_sr    <= '0;
    end else begin
        if (o_req.wen | o_req.ren | (csb_rise & ~frm_ok)) begin
            rsp_word <= rsp_nxt;
        end
        if (csb_fall) begin
            tx_sr <= rsp_word;
        end else if (sclk_fall) begin
            tx_sr <= {tx_sr[SPI_FRAME_W-2:0], 1'b0};
        end
    end
end

assign o_spi_miso = tx_sr[SPI_FRAME_W-1];

endmodule

// ==== verilog/hv_ctrl_pkg.sv ====
// control side types: state encoding, spi frame, register access
// a register request is a single cycle pulse, answered in the same cycle
package hv_ctrl_pkg;

import hv_reg_pkg::*;

typedef enum logic [1:0] {
    INIT   = 2'd0,
    CFG    = 2'd1,
    NORMAL = 2'd2,
    FAULT  = 2'd3
} ctrl_st_e;

localparam int SPI_FRAME_W = 1 + REG_AW + REG_DW + CRC_W;

// shifted msb first
typedef struct packed {
    logic              rw;    // 1 = write
    logic [REG_AW-1:0] addr;
    logic [REG_DW-1:0] data;
    logic [CRC_W-1:0]  crc;
} spi_frame_t;

typedef struct packed {
    logic              wen;
    logic              ren;
    logic [REG_AW-1:0] addr;
    logic [REG_DW-1:0] wdata;
} reg_req_t;

typedef struct packed {
    logic              ack;
    logic [REG_DW-1:0] rdata;
} reg_rsp_t;

typedef struct packed {
    logic spi_err;
    logic wdg_tmo;
    logic pwm_fs;
} err_evt_t;

localparam int WDG_TICK  = 64;                     // clocks per timeout unit
localparam int WDG_CNT_W = $clog2(16 * WDG_TICK);  // holds 15 units

endpackage

// ==== verilog/hv_reg_pkg.sv ====
// register map of the low voltage control core
// 7-bit address, 8-bit data, crc-8 poly 0x07 with zero init, msb first
// drive config bytes 0x10..0x13 are writable only in the CFG state
package hv_reg_pkg;

//======================================================================
// widths and addresses
//======================================================================
localparam int REG_AW = 7;
localparam int REG_DW = 8;
localparam int CRC_W  = 8;

localparam logic [CRC_W-1:0]  CRC_POLY         = 8'h07;

localparam logic [REG_AW-1:0] ADDR_MODE        = 7'h00;
localparam logic [REG_AW-1:0] ADDR_STATUS1     = 7'h01;
localparam logic [REG_AW-1:0] ADDR_STATE       = 7'h02;
localparam logic [REG_AW-1:0] ADDR_COM_CONFIG2 = 7'h03;  // watchdog timeout
localparam logic [REG_AW-1:0] ADDR_WDG_REFRESH = 7'h04;
localparam logic [REG_AW-1:0] ADDR_DRV_CFG0    = 7'h10;  // four bytes

//======================================================================
// register layouts
//======================================================================
typedef struct packed {
    logic [5:0] rsvd;
    logic       reset_en;
    logic       normal_en;
} reg_mode_t;

typedef struct packed {
    logic [4:0] rsvd;
    logic       pwm_fs_err;
    logic       wdg_tmo_err;
    logic       spi_err;
} reg_status1_t;

// byte 0 sits in the low bits
typedef struct packed {
    logic [REG_DW-1:0] tltoff_sel;
    logic [REG_DW-1:0] snk_sel;
    logic [REG_DW-1:0] src_sel;
    logic [REG_DW-1:0] src_snk_both;
} drv_cfg_t;

localparam drv_cfg_t DRV_CFG_RST = 32'h04_33_22_01;

// crc over rw, addr and data of one frame
function automatic logic [CRC_W-1:0] crc8_calc(input logic [REG_AW+REG_DW:0] din);
    logic [CRC_W-1:0] crc;
    crc = '0;
    for (int i = REG_AW + REG_DW; i >= 0; i--) begin
        if (crc[CRC_W-1] ^ din[i]) begin
            crc = (crc << 1) ^ CRC_POLY;
        end else begin
            crc = crc << 1;
        end
    end
    return crc;
endfunction

endpackage
